//--- bench/tb_core_block_pr.sv
`timescale 1ns/1ps

module tb_core_block_pr;

  localparam int NUM_ENTRIES   = 24;
  localparam int KIND_WR       = 0;
  localparam int KIND_RD       = 1;
  localparam int KIND_DESC     = 2;
  localparam int KIND_BC       = 3;
  localparam int FIXED_LATENCY = 5;
  localparam logic [pr_pkg::CORE_ID_WIDTH-1:0] TB_CORE_ID = 4'h5;

  typedef struct {
    int                             kind;
    logic [pr_pkg::ADDR_WIDTH-1:0]  addr;
    logic [pr_pkg::DATA_WIDTH-1:0]  data;
    logic [pr_pkg::STRB_WIDTH-1:0]  strb;
    logic [pr_pkg::CORE_ID_WIDTH-1:0] src;
    bit                             timed;
    logic [pr_pkg::DATA_WIDTH-1:0]  exp_data;
    logic [pr_pkg::DATA_WIDTH-1:0]  exp_dram;
    logic [pr_pkg::MSG_WIDTH-1:0]   exp_msg;
  } entry_t;

  logic                             sys_clk = 1'b0;
  logic                             arst_n;
  logic [pr_pkg::CORE_ID_WIDTH-1:0] core_id;
  logic                             dma_cmd_wr_en, dma_cmd_wr_ready;
  logic [pr_pkg::ADDR_WIDTH-1:0]    dma_cmd_wr_addr, dma_cmd_rd_addr;
  logic [pr_pkg::DATA_WIDTH-1:0]    dma_cmd_wr_data;
  logic [pr_pkg::STRB_WIDTH-1:0]    dma_cmd_wr_strb;
  logic                             dma_cmd_rd_en, dma_cmd_rd_ready;
  logic                             dma_rd_resp_valid, dma_rd_resp_ready;
  logic [pr_pkg::DATA_WIDTH-1:0]    dma_rd_resp_data;
  logic [pr_pkg::DATA_WIDTH-1:0]    in_desc, out_desc, out_desc_dram_addr;
  logic                             in_desc_valid, in_desc_taken;
  logic                             out_desc_valid, out_desc_ready;
  logic [pr_pkg::MSG_WIDTH-1:0]     bc_msg_in, bc_msg_out;
  logic                             bc_msg_in_valid, bc_msg_out_valid, bc_msg_out_ready;

  entry_t                        tbl [NUM_ENTRIES];
  int                            accept_cycle [NUM_ENTRIES];
  logic [pr_pkg::DATA_WIDTH-1:0] model_mem [pr_pkg::DMEM_WORDS];
  int                            resp_q[$];
  int                            desc_q[$];
  int                            msg_q[$];
  integer                        seed = 32'h3524;
  logic [31:0]                   rnd;
  int                            cycle_cnt = 0;
  int                            tests = 0;
  int                            failures = 0;
  bit                            hold_ready;
  bit                            hold_now;

  core_block_pr #(.REG_LENGTH(2)) u_core_block_pr (
    .sys_clk, .arst_n, .core_id,
    .dma_cmd_wr_en, .dma_cmd_wr_addr, .dma_cmd_wr_data, .dma_cmd_wr_strb, .dma_cmd_wr_ready,
    .dma_cmd_rd_en, .dma_cmd_rd_addr, .dma_cmd_rd_ready,
    .dma_rd_resp_valid, .dma_rd_resp_data, .dma_rd_resp_ready,
    .in_desc, .in_desc_valid, .in_desc_taken,
    .out_desc, .out_desc_dram_addr, .out_desc_valid, .out_desc_ready,
    .bc_msg_in, .bc_msg_in_valid,
    .bc_msg_out, .bc_msg_out_valid, .bc_msg_out_ready
  );

  always #5 sys_clk = ~sys_clk;

  always @(posedge sys_clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // Output side readys, random unless a timed entry holds them high
  always @(posedge sys_clk) begin
    hold_now = hold_ready;
    #1;
    rnd = $random(seed);
    if (hold_now) begin
      {dma_rd_resp_ready, out_desc_ready, bc_msg_out_ready} = 3'b111;
    end else begin
      {dma_rd_resp_ready, out_desc_ready, bc_msg_out_ready} = rnd[2:0];
    end
  end

  ////////////////////////////////////////
  // Table and reference model

  task automatic set_entry(input int i, input int kind, input logic [15:0] addr,
                           input logic [7:0] strb, input logic [3:0] src, input bit timed);
    tbl[i].kind  = kind;
    tbl[i].addr  = addr;
    tbl[i].strb  = strb;
    tbl[i].src   = src;
    tbl[i].timed = timed;
    tbl[i].data  = {$random(seed), $random(seed)};
    // Lookup address rides in the low 16 bits
    if (kind == KIND_DESC) begin
      tbl[i].data[15:0] = addr;
    end
  endtask

  task automatic fill_table();
    set_entry(0,  KIND_WR,   16'h0040, 8'hff, 4'h0, 1'b0);
    set_entry(1,  KIND_RD,   16'h0040, 8'h00, 4'h0, 1'b0);
    set_entry(2,  KIND_WR,   16'h0046, 8'ha5, 4'h0, 1'b0);
    set_entry(3,  KIND_RD,   16'h0041, 8'h00, 4'h0, 1'b0);
    set_entry(4,  KIND_WR,   16'h0128, 8'hff, 4'h0, 1'b0);
    set_entry(5,  KIND_WR,   16'h0320, 8'hff, 4'h0, 1'b0);
    set_entry(6,  KIND_DESC, 16'h8043, 8'h00, 4'h0, 1'b0);
    set_entry(7,  KIND_DESC, 16'h012d, 8'h00, 4'h0, 1'b0);
    // Words 1030 and 1031 sit in the broadcast region
    set_entry(8,  KIND_WR,   16'h2030, 8'hff, 4'h0, 1'b0);
    set_entry(9,  KIND_WR,   16'h2038, 8'hff, 4'h0, 1'b0);
    set_entry(10, KIND_BC,   16'd6,    8'h00, 4'h3, 1'b0);
    set_entry(11, KIND_RD,   16'h2030, 8'h00, 4'h0, 1'b0);
    set_entry(12, KIND_BC,   16'd7,    8'h00, TB_CORE_ID, 1'b0);
    set_entry(13, KIND_RD,   16'h2038, 8'h00, 4'h0, 1'b0);
    // Back to back traffic under random back-pressure
    set_entry(14, KIND_RD,   16'h0040, 8'h00, 4'h0, 1'b0);
    set_entry(15, KIND_DESC, 16'h0322, 8'h00, 4'h0, 1'b0);
    set_entry(16, KIND_RD,   16'h0128, 8'h00, 4'h0, 1'b0);
    set_entry(17, KIND_RD,   16'h0320, 8'h00, 4'h0, 1'b0);
    set_entry(18, KIND_DESC, 16'h4129, 8'h00, 4'h0, 1'b0);
    set_entry(19, KIND_RD,   16'h2030, 8'h00, 4'h0, 1'b0);
    set_entry(20, KIND_DESC, 16'h2031, 8'h00, 4'h0, 1'b0);
    set_entry(21, KIND_RD,   16'h2038, 8'h00, 4'h0, 1'b0);
    set_entry(22, KIND_RD,   16'h0128, 8'h00, 4'h0, 1'b1);
    set_entry(23, KIND_DESC, 16'h0320, 8'h00, 4'h0, 1'b1);
  endtask

  task automatic apply_to_model(input int i);
    int w;
    w = tbl[i].addr[13:3];
    case (tbl[i].kind)
      KIND_WR: begin
        for (int b = 0; b < pr_pkg::STRB_WIDTH; b++) begin
          if (tbl[i].strb[b]) begin
            model_mem[w][8*b +: 8] = tbl[i].data[8*b +: 8];
          end
        end
      end
      KIND_RD: begin
        tbl[i].exp_data = model_mem[w];
        resp_q.push_back(i);
      end
      KIND_DESC: begin
        w = tbl[i].data[13:3];
        tbl[i].exp_dram = model_mem[w];
        tbl[i].exp_msg  = {TB_CORE_ID, tbl[i].data[12:3], tbl[i].data[63:32]};
        desc_q.push_back(i);
        msg_q.push_back(i);
      end
      default: begin
        // Own messages are dropped by the core
        if (tbl[i].src != TB_CORE_ID) begin
          w = pr_pkg::BC_START_WORD + tbl[i].addr[9:0];
          model_mem[w][31:0] = tbl[i].data[31:0];
        end
      end
    endcase
  endtask

  ////////////////////////////////////////
  // Driving and checking

  function automatic bit cmd_ready(input int kind);
    case (kind)
      KIND_WR:   return dma_cmd_wr_ready;
      KIND_RD:   return dma_cmd_rd_ready;
      KIND_DESC: return in_desc_taken;
      default:   return 1'b1;
    endcase
  endfunction

  task automatic report(input string what, input int i, input bit ok);
    tests++;
    if (!ok) begin
      failures++;
    end
    $display("entry %0d %s addr %h: %s", i, what, tbl[i].addr, ok ? "ok" : "FAILED");
  endtask

  task automatic issue_entry(input int i);
    case (tbl[i].kind)
      KIND_WR: begin
        dma_cmd_wr_addr = tbl[i].addr;
        dma_cmd_wr_data = tbl[i].data;
        dma_cmd_wr_strb = tbl[i].strb;
        dma_cmd_wr_en   = 1'b1;
      end
      KIND_RD: begin
        dma_cmd_rd_addr = tbl[i].addr;
        dma_cmd_rd_en   = 1'b1;
      end
      KIND_DESC: begin
        in_desc       = tbl[i].data;
        in_desc_valid = 1'b1;
      end
      default: begin
        bc_msg_in       = {tbl[i].src, tbl[i].addr[9:0], tbl[i].data[31:0]};
        bc_msg_in_valid = 1'b1;
      end
    endcase
    @(negedge sys_clk);
    while (!cmd_ready(tbl[i].kind)) begin
      @(negedge sys_clk);
    end
    accept_cycle[i] = cycle_cnt + 1;
    @(posedge sys_clk);
    #1;
    dma_cmd_wr_en   = 1'b0;
    dma_cmd_rd_en   = 1'b0;
    in_desc_valid   = 1'b0;
    bc_msg_in_valid = 1'b0;
  endtask

  task automatic wait_drained();
    while (resp_q.size() != 0 || desc_q.size() != 0 || msg_q.size() != 0) begin
      @(posedge sys_clk);
      #1;
    end
  endtask

  task automatic compare(input string name, input int i, input logic [63:0] got,
                         input logic [63:0] exp, inout bit ok);
    assert (got === exp) else begin
      $display("CHECK FAILED %s entry %0d: got %h expected %h", name, i, got, exp);
      ok = 1'b0;
    end
  endtask

  task automatic check_latency(input string what, input int i, inout bit ok);
    int took;
    took = cycle_cnt + 1 - accept_cycle[i];
    if (tbl[i].timed) begin
      assert (took == FIXED_LATENCY) else begin
        $display("%s of entry %0d came %0d cycles after acceptance instead of %0d",
                 what, i, took, FIXED_LATENCY);
        ok = 1'b0;
      end
    end
  endtask

  task automatic take_output(input int port);
    int i;
    bit ok;
    ok = 1'b1;
    if ((port == 0 && resp_q.size() == 0) || (port == 1 && desc_q.size() == 0) ||
        (port == 2 && msg_q.size() == 0)) begin
      $display("Output %0d delivered a transfer that nothing asked for", port);
      failures++;
    end else if (port == 0) begin
      i = resp_q.pop_front();
      compare("dma_rd_resp_data", i, dma_rd_resp_data, tbl[i].exp_data, ok);
      check_latency("Read response", i, ok);
      report("read", i, ok);
    end else if (port == 1) begin
      i = desc_q.pop_front();
      compare("out_desc", i, out_desc, tbl[i].data, ok);
      compare("out_desc_dram_addr", i, out_desc_dram_addr, tbl[i].exp_dram, ok);
      check_latency("Outgoing descriptor", i, ok);
      report("descriptor", i, ok);
    end else begin
      i = msg_q.pop_front();
      compare("bc_msg_out", i, 64'(bc_msg_out), 64'(tbl[i].exp_msg), ok);
      check_latency("Broadcast message", i, ok);
      report("broadcast out", i, ok);
    end
  endtask

  always @(negedge sys_clk) begin
    if (arst_n) begin
      if (dma_rd_resp_valid && dma_rd_resp_ready) begin
        take_output(0);
      end
      if (out_desc_valid && out_desc_ready) begin
        take_output(1);
      end
      if (bc_msg_out_valid && bc_msg_out_ready) begin
        take_output(2);
      end
    end
  end

  initial begin
    repeat (NUM_ENTRIES * 50) @(posedge sys_clk);
    $display("Watchdog expired after %0d cycles before the table finished", NUM_ENTRIES * 50);
    $display("Testbench failed");
    $finish;
  end

  initial begin
    arst_n          = 1'b0;
    core_id         = TB_CORE_ID;
    dma_cmd_wr_en   = 1'b0;
    dma_cmd_wr_addr = '0;
    dma_cmd_wr_data = '0;
    dma_cmd_wr_strb = '0;
    dma_cmd_rd_en   = 1'b0;
    dma_cmd_rd_addr = '0;
    in_desc         = '0;
    in_desc_valid   = 1'b0;
    bc_msg_in       = '0;
    bc_msg_in_valid = 1'b0;
    dma_rd_resp_ready = 1'b0;
    out_desc_ready    = 1'b0;
    bc_msg_out_ready  = 1'b0;
    hold_ready        = 1'b0;
    fill_table();
    repeat (3) @(posedge sys_clk);
    #1;
    arst_n = 1'b1;
    repeat (2) @(posedge sys_clk);
    #1;
    tests++;
    assert (!dma_rd_resp_valid && !out_desc_valid && !bc_msg_out_valid &&
            dma_cmd_wr_ready && dma_cmd_rd_ready && in_desc_taken) else begin
      $display("Valid or ready outputs are wrong after reset");
      failures++;
    end
    $display("reset state checked");

    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (tbl[i].kind == KIND_WR || tbl[i].kind == KIND_BC || tbl[i].timed) begin
        wait_drained();
      end
      apply_to_model(i);
      if (tbl[i].timed) begin
        hold_ready = 1'b1;
        @(posedge sys_clk);
        #1;
      end
      issue_entry(i);
      if (tbl[i].timed) begin
        wait_drained();
        hold_ready = 1'b0;
      end
    end
    wait_drained();
    // Quiet period to catch duplicated outputs
    repeat (20) @(posedge sys_clk);

    $display("%0d tests run, %0d failed", tests, failures);
    if (failures == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- hw/core_block.sv
`timescale 1ns/1ps

module core_block (
  input  logic                             sys_clk,
  input  logic                             arst_n,
  input  logic [pr_pkg::CORE_ID_WIDTH-1:0] core_id,
  input  pr_pkg::dma_wr_t                  wr,
  input  logic                             wr_valid,
  output logic                             wr_ready,
  input  pr_pkg::dma_rd_t                  rd,
  input  logic                             rd_valid,
  output logic                             rd_ready,
  output logic [pr_pkg::DATA_WIDTH-1:0]    resp_data,
  output logic                             resp_valid,
  input  logic                             resp_ready,
  input  logic [pr_pkg::DATA_WIDTH-1:0]    in_desc,
  input  logic                             in_desc_valid,
  output logic                             in_desc_taken,
  output pr_pkg::desc_out_t                out_desc,
  output logic                             out_desc_valid,
  input  logic                             out_desc_ready,
  input  pr_pkg::bc_msg_t                  bc_in,
  input  logic                             bc_in_valid,
  output pr_pkg::bc_msg_t                  bc_out,
  output logic                             bc_out_valid,
  input  logic                             bc_out_ready
);

  logic [pr_pkg::CORE_ID_WIDTH-1:0] core_id_q;

  dmem_rd_if lookup ();

  // Core id is static config, one flop is enough
  always_ff @(posedge sys_clk or negedge arst_n) begin
    if (!arst_n) begin
      core_id_q <= '0;
    end else begin
      core_id_q <= core_id;
    end
  end

  local_dmem u_local_dmem (
    .sys_clk, .arst_n,
    .wr, .wr_valid, .wr_ready,
    .rd, .rd_valid, .rd_ready,
    .resp_data, .resp_valid, .resp_ready,
    .bc(bc_in), .bc_valid(bc_in_valid),
    .core_id(core_id_q),
    .eng(lookup.slave)
  );

  desc_engine u_desc_engine (
    .sys_clk, .arst_n,
    .core_id(core_id_q),
    .in_desc, .in_desc_valid, .in_desc_taken,
    .out(out_desc), .out_valid(out_desc_valid), .out_ready(out_desc_ready),
    .bc_out, .bc_out_valid, .bc_out_ready,
    .mem(lookup.master)
  );

endmodule

//--- hw/core_block_pr.sv
`timescale 1ns/1ps

module core_block_pr #(
  parameter int REG_LENGTH = 2
) (
  input  logic                             sys_clk,
  input  logic                             arst_n,
  input  logic [pr_pkg::CORE_ID_WIDTH-1:0] core_id,

  input  logic                             dma_cmd_wr_en,
  input  logic [pr_pkg::ADDR_WIDTH-1:0]    dma_cmd_wr_addr,
  input  logic [pr_pkg::DATA_WIDTH-1:0]    dma_cmd_wr_data,
  input  logic [pr_pkg::STRB_WIDTH-1:0]    dma_cmd_wr_strb,
  output logic                             dma_cmd_wr_ready,
  input  logic                             dma_cmd_rd_en,
  input  logic [pr_pkg::ADDR_WIDTH-1:0]    dma_cmd_rd_addr,
  output logic                             dma_cmd_rd_ready,
  output logic                             dma_rd_resp_valid,
  output logic [pr_pkg::DATA_WIDTH-1:0]    dma_rd_resp_data,
  input  logic                             dma_rd_resp_ready,

  input  logic [pr_pkg::DATA_WIDTH-1:0]    in_desc,
  input  logic                             in_desc_valid,
  output logic                             in_desc_taken,
  output logic [pr_pkg::DATA_WIDTH-1:0]    out_desc,
  output logic [pr_pkg::DATA_WIDTH-1:0]    out_desc_dram_addr,
  output logic                             out_desc_valid,
  input  logic                             out_desc_ready,

  input  logic [pr_pkg::MSG_WIDTH-1:0]     bc_msg_in,
  input  logic                             bc_msg_in_valid,
  output logic [pr_pkg::MSG_WIDTH-1:0]     bc_msg_out,
  output logic                             bc_msg_out_valid,
  input  logic                             bc_msg_out_ready
);

  pr_pkg::dma_wr_t               wr_in, wr_r;
  pr_pkg::dma_rd_t               rd_in, rd_r;
  logic                          wr_valid_r, wr_ready_r, rd_valid_r, rd_ready_r;
  logic [pr_pkg::DATA_WIDTH-1:0] resp_data_n, in_desc_r;
  logic                          resp_valid_n, resp_ready_n;
  logic                          in_desc_valid_r, in_desc_taken_r;
  pr_pkg::desc_out_t             out_n, out_m;
  logic                          out_valid_n, out_ready_n;
  pr_pkg::bc_msg_t               bc_in_r, bc_out_n;
  logic                          bc_in_valid_r, bc_out_valid_n, bc_out_ready_n;

  assign wr_in.data = dma_cmd_wr_data;
  assign wr_in.addr = dma_cmd_wr_addr;
  assign wr_in.strb = dma_cmd_wr_strb;
  assign rd_in.addr = dma_cmd_rd_addr;

  assign out_desc           = out_m.desc;
  assign out_desc_dram_addr = out_m.dram_addr;

  ////////////////////////////////////////
  // Input chains

  pipe_reg #(.T(pr_pkg::dma_wr_t), .REG_LENGTH(REG_LENGTH)) u_dma_wr_reg (
    .sys_clk, .arst_n,
    .s_data(wr_in), .s_valid(dma_cmd_wr_en), .s_ready(dma_cmd_wr_ready),
    .m_data(wr_r), .m_valid(wr_valid_r), .m_ready(wr_ready_r)
  );

  pipe_reg #(.T(pr_pkg::dma_rd_t), .REG_LENGTH(REG_LENGTH)) u_dma_rd_reg (
    .sys_clk, .arst_n,
    .s_data(rd_in), .s_valid(dma_cmd_rd_en), .s_ready(dma_cmd_rd_ready),
    .m_data(rd_r), .m_valid(rd_valid_r), .m_ready(rd_ready_r)
  );

  pipe_reg #(.T(logic [pr_pkg::DATA_WIDTH-1:0]), .REG_LENGTH(REG_LENGTH)) u_in_desc_reg (
    .sys_clk, .arst_n,
    .s_data(in_desc), .s_valid(in_desc_valid), .s_ready(in_desc_taken),
    .m_data(in_desc_r), .m_valid(in_desc_valid_r), .m_ready(in_desc_taken_r)
  );

  // Broadcast ring has no back-pressure
  pipe_reg #(.T(pr_pkg::bc_msg_t), .REG_LENGTH(REG_LENGTH)) u_bc_in_reg (
    .sys_clk, .arst_n,
    .s_data(bc_msg_in), .s_valid(bc_msg_in_valid), .s_ready(),
    .m_data(bc_in_r), .m_valid(bc_in_valid_r), .m_ready(1'b1)
  );

  ////////////////////////////////////////
  // Output chains

  pipe_reg #(.T(logic [pr_pkg::DATA_WIDTH-1:0]), .REG_LENGTH(REG_LENGTH)) u_rd_resp_reg (
    .sys_clk, .arst_n,
    .s_data(resp_data_n), .s_valid(resp_valid_n), .s_ready(resp_ready_n),
    .m_data(dma_rd_resp_data), .m_valid(dma_rd_resp_valid), .m_ready(dma_rd_resp_ready)
  );

  pipe_reg #(.T(pr_pkg::desc_out_t), .REG_LENGTH(REG_LENGTH)) u_out_desc_reg (
    .sys_clk, .arst_n,
    .s_data(out_n), .s_valid(out_valid_n), .s_ready(out_ready_n),
    .m_data(out_m), .m_valid(out_desc_valid), .m_ready(out_desc_ready)
  );

  pipe_reg #(.T(pr_pkg::bc_msg_t), .REG_LENGTH(REG_LENGTH)) u_bc_out_reg (
    .sys_clk, .arst_n,
    .s_data(bc_out_n), .s_valid(bc_out_valid_n), .s_ready(bc_out_ready_n),
    .m_data(bc_msg_out), .m_valid(bc_msg_out_valid), .m_ready(bc_msg_out_ready)
  );

  ////////////////////////////////////////
  // Core

  core_block u_core_block (
    .sys_clk, .arst_n, .core_id,
    .wr(wr_r), .wr_valid(wr_valid_r), .wr_ready(wr_ready_r),
    .rd(rd_r), .rd_valid(rd_valid_r), .rd_ready(rd_ready_r),
    .resp_data(resp_data_n), .resp_valid(resp_valid_n), .resp_ready(resp_ready_n),
    .in_desc(in_desc_r), .in_desc_valid(in_desc_valid_r), .in_desc_taken(in_desc_taken_r),
    .out_desc(out_n), .out_desc_valid(out_valid_n), .out_desc_ready(out_ready_n),
    .bc_in(bc_in_r), .bc_in_valid(bc_in_valid_r),
    .bc_out(bc_out_n), .bc_out_valid(bc_out_valid_n), .bc_out_ready(bc_out_ready_n)
  );

endmodule

//--- hw/desc_engine.sv
`timescale 1ns/1ps

module desc_engine (
  input  logic                             sys_clk,
  input  logic                             arst_n,
  input  logic [pr_pkg::CORE_ID_WIDTH-1:0] core_id,
  input  logic [pr_pkg::DATA_WIDTH-1:0]    in_desc,
  input  logic                             in_desc_valid,
  output logic                             in_desc_taken,
  output pr_pkg::desc_out_t                out,
  output logic                             out_valid,
  input  logic                             out_ready,
  output pr_pkg::bc_msg_t                  bc_out,
  output logic                             bc_out_valid,
  input  logic                             bc_out_ready,
  dmem_rd_if.master                        mem
);

  logic                               accept;
  logic [pr_pkg::WORD_ADDR_WIDTH-1:0] desc_word;
  logic [pr_pkg::DATA_WIDTH-1:0]      desc_q;
  logic [pr_pkg::DATA_WIDTH-1:0]      dram_q;

  assign in_desc_taken = !out_valid && !bc_out_valid;
  assign accept        = in_desc_valid && in_desc_taken;
  assign desc_word     = pr_pkg::word_of(in_desc[pr_pkg::ADDR_WIDTH-1:0]);

  // Lookup issued in the accept cycle
  assign mem.rd_en   = accept;
  assign mem.rd_word = desc_word;

  always_ff @(posedge sys_clk) begin
    if (accept) begin
      desc_q        <= in_desc;
      bc_out.src_id <= core_id;
      bc_out.offset <= desc_word[pr_pkg::BC_ADDR_WIDTH-1:0];
      bc_out.data   <= in_desc[pr_pkg::DATA_WIDTH-1 -: pr_pkg::BC_DATA_WIDTH];
    end
    if (mem.rd_valid) begin
      dram_q <= mem.rd_data;
    end
  end

  // Lookup data shows up once, keep it while out waits
  assign out.desc      = desc_q;
  assign out.dram_addr = mem.rd_valid ? mem.rd_data : dram_q;

  always_ff @(posedge sys_clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid    <= 1'b0;
      bc_out_valid <= 1'b0;
    end else if (accept) begin
      out_valid    <= 1'b1;
      bc_out_valid <= 1'b1;
    end else begin
      if (out_ready) begin
        out_valid <= 1'b0;
      end
      if (bc_out_ready) begin
        bc_out_valid <= 1'b0;
      end
    end
  end

  // Memory answers the cycle after accept
  a_lookup_timing: assert property (@(posedge sys_clk) disable iff (!arst_n)
    accept |=> mem.rd_valid);

endmodule

//--- hw/dmem_rd_if.sv
`timescale 1ns/1ps

// Engine lookup port, data comes back one cycle after rd_en
interface dmem_rd_if;

  logic                               rd_en;
  logic [pr_pkg::WORD_ADDR_WIDTH-1:0] rd_word;
  logic [pr_pkg::DATA_WIDTH-1:0]      rd_data;
  logic                               rd_valid;

  modport master (
    output rd_en,
    output rd_word,
    input  rd_data,
    input  rd_valid
  );

  modport slave (
    input  rd_en,
    input  rd_word,
    output rd_data,
    output rd_valid
  );

endinterface

//--- hw/local_dmem.sv
`timescale 1ns/1ps

module local_dmem (
  input  logic                             sys_clk,
  input  logic                             arst_n,
  input  pr_pkg::dma_wr_t                  wr,
  input  logic                             wr_valid,
  output logic                             wr_ready,
  input  pr_pkg::dma_rd_t                  rd,
  input  logic                             rd_valid,
  output logic                             rd_ready,
  output logic [pr_pkg::DATA_WIDTH-1:0]    resp_data,
  output logic                             resp_valid,
  input  logic                             resp_ready,
  input  pr_pkg::bc_msg_t                  bc,
  input  logic                             bc_valid,
  input  logic [pr_pkg::CORE_ID_WIDTH-1:0] core_id,
  dmem_rd_if.slave                         eng
);

  logic [pr_pkg::DATA_WIDTH-1:0] mem [pr_pkg::DMEM_WORDS];

  logic                               bc_hit;
  logic [pr_pkg::WORD_ADDR_WIDTH-1:0] bc_word;
  logic [pr_pkg::WORD_ADDR_WIDTH-1:0] wr_word;
  logic                               wr_fire;
  logic                               rd_fire;

  // Own messages come back on the ring and are dropped
  assign bc_hit  = bc_valid && (bc.src_id != core_id);
  assign bc_word = pr_pkg::BC_START_WORD[pr_pkg::WORD_ADDR_WIDTH-1:0] + bc.offset;
  assign wr_word = pr_pkg::word_of(wr.addr);

  assign wr_ready = !bc_hit;
  assign wr_fire  = wr_valid && wr_ready;
  assign rd_ready = !resp_valid || resp_ready;
  assign rd_fire  = rd_valid && rd_ready;

  ////////////////////////////////////////
  // Write port

  always_ff @(posedge sys_clk) begin
    if (bc_hit) begin
      mem[bc_word][pr_pkg::BC_DATA_WIDTH-1:0] <= bc.data;
    end else if (wr_fire) begin
      for (int b = 0; b < pr_pkg::STRB_WIDTH; b++) begin
        if (wr.strb[b]) begin
          mem[wr_word][8*b +: 8] <= wr.data[8*b +: 8];
        end
      end
    end
  end

  ////////////////////////////////////////
  // Read ports

  always_ff @(posedge sys_clk) begin
    if (rd_fire) begin
      resp_data <= mem[pr_pkg::word_of(rd.addr)];
    end
    if (eng.rd_en) begin
      eng.rd_data <= mem[eng.rd_word];
    end
  end

  always_ff @(posedge sys_clk or negedge arst_n) begin
    if (!arst_n) begin
      resp_valid   <= 1'b0;
      eng.rd_valid <= 1'b0;
    end else begin
      eng.rd_valid <= eng.rd_en;
      if (rd_fire) begin
        resp_valid <= 1'b1;
      end else if (resp_ready) begin
        resp_valid <= 1'b0;
      end
    end
  end

endmodule

//--- hw/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
  parameter type T          = logic,
  parameter int  REG_LENGTH = 2
) (
  input  logic sys_clk,
  input  logic arst_n,
  input  T     s_data,
  input  logic s_valid,
  output logic s_ready,
  output T     m_data,
  output logic m_valid,
  input  logic m_ready
);

  T                      stage_data [REG_LENGTH];
  logic [REG_LENGTH-1:0] stage_valid;
  logic [REG_LENGTH-1:0] stage_ready;

  // Index 0 is the chain input, index REG_LENGTH the chain output
  T                      fill_data [REG_LENGTH+1];
  logic [REG_LENGTH:0]   fill_valid;

  assign fill_valid = {stage_valid, s_valid};

  // A stage may load when some stage at or after it is empty,
  // or when the consumer takes the head this cycle
  always_comb begin
    fill_data[0] = s_data;
    for (int i = 0; i < REG_LENGTH; i++) begin
      fill_data[i+1] = stage_data[i];
      stage_ready[i] = m_ready || (|((~stage_valid) >> i));
    end
  end

  always_ff @(posedge sys_clk or negedge arst_n) begin
    if (!arst_n) begin
      stage_valid <= '0;
    end else begin
      for (int i = 0; i < REG_LENGTH; i++) begin
        if (stage_ready[i]) begin
          stage_valid[i] <= fill_valid[i];
        end
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    for (int i = 0; i < REG_LENGTH; i++) begin
      if (stage_ready[i] && fill_valid[i]) begin
        stage_data[i] <= fill_data[i];
      end
    end
  end

  assign s_ready = stage_ready[0];
  assign m_valid = fill_valid[REG_LENGTH];
  assign m_data  = fill_data[REG_LENGTH];

  // Stalled head must not change or vanish
  a_hold_stalled: assert property (@(posedge sys_clk) disable iff (!arst_n)
    m_valid && !m_ready |=> m_valid && $stable(m_data));

endmodule

//--- hw/pr_pkg.sv
package pr_pkg;

  // Memory and bus geometry
  localparam int DATA_WIDTH      = 64;
  localparam int STRB_WIDTH      = DATA_WIDTH / 8;
  localparam int ADDR_WIDTH      = 16;
  localparam int DMEM_WORDS      = 2048;
  localparam int WORD_ADDR_WIDTH = $clog2(DMEM_WORDS);
  localparam int WORD_LSB        = $clog2(STRB_WIDTH);

  // Broadcast region occupies the upper half of local memory
  localparam int BC_START_WORD   = 1024;
  localparam int BC_ADDR_WIDTH   = 10;
  localparam int BC_DATA_WIDTH   = 32;
  localparam int CORE_ID_WIDTH   = 4;
  localparam int MSG_WIDTH       = CORE_ID_WIDTH + BC_ADDR_WIDTH + BC_DATA_WIDTH;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic [ADDR_WIDTH-1:0] addr;
    logic [STRB_WIDTH-1:0] strb;
  } dma_wr_t;

  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
  } dma_rd_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] desc;
    logic [DATA_WIDTH-1:0] dram_addr;
  } desc_out_t;

  typedef struct packed {
    logic [CORE_ID_WIDTH-1:0] src_id;
    logic [BC_ADDR_WIDTH-1:0] offset;
    logic [BC_DATA_WIDTH-1:0] data;
  } bc_msg_t;

  // Byte address to memory word index
  function automatic logic [WORD_ADDR_WIDTH-1:0] word_of(input logic [ADDR_WIDTH-1:0] addr);
    return addr[WORD_LSB +: WORD_ADDR_WIDTH];
  endfunction

endpackage

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module tb_core_block_pr -f tb.f

./obj_dir/Vtb_core_block_pr | tee /dev/stderr | grep -x "Testbench passed" > /dev/null

echo "run_sim: pass message found"

//--- tb.f
hw/pr_pkg.sv
hw/dmem_rd_if.sv
hw/pipe_reg.sv
hw/local_dmem.sv
hw/desc_engine.sv
hw/core_block.sv
hw/core_block_pr.sv
bench/tb_core_block_pr.sv
